// ==== bench/chipbus_tb.sv ====
/*
  testbench for the cpu bus fabric
  slaves answer with random words, fresh for every request
  sof pulses every SOF_PERIOD cycles for the whole run
  concurrent assertions check, the first failure stops the run
*/
`timescale 1ns/1ps
`default_nettype none

module chipbus_tb;
	import chipbus_pkg::*;

	localparam int SOF_PERIOD      = 20;
	localparam int ACK_TIMEOUT     = 8;
	localparam int IRQ_CYCLES      = 48;
	localparam int RELEASE_TIMEOUT = (RESET_HOLD_FRAMES + 2) * SOF_PERIOD;
	localparam int WATCHDOG_CYCLES = 2000; // tests need about 250 cycles

	// select patterns, bit order chip kick cia_a cia_b custom rtc
	localparam region_sel_t SEL_NONE   = 6'b000000;
	localparam region_sel_t SEL_CHIP   = 6'b100000;
	localparam region_sel_t SEL_KICK   = 6'b010000;
	localparam region_sel_t SEL_CIA_A  = 6'b001000;
	localparam region_sel_t SEL_CIA_B  = 6'b000100;
	localparam region_sel_t SEL_CIA_AB = 6'b001100;
	localparam region_sel_t SEL_CUSTOM = 6'b000010;
	localparam region_sel_t SEL_RTC    = 6'b000001;

	logic                  clk;
	logic                  rst_n;
	logic                  rst_ext;
	logic                  sof;
	cpu_req_t              req;
	slave_rdata_t          rdata;
	logic [IRQ_LEVELS-1:0] int_req;
	logic                  nmi;
	region_sel_t           sel;
	data_t                 cpu_rdata;
	logic                  ack;
	logic [2:0]            ipl_n;
	logic                  sys_reset;
	logic                  cpu_reset_n;

	integer      seed = 32'h1e3cd8b2;
	region_sel_t exp_sel;   // decode of the request in flight
	data_t       exp_rdata;
	region_sel_t sel_prev;  // sel one cycle back
	logic [2:0]  exp_ipl;
	logic [1:0]  ext_pipe;  // rst_ext after the two sync stages
	int          sof_cnt;   // sof pulses since the last reset cause

	chipbus_top UUT (.*);

	// ------------------------------------------------------------
	// reference rules
	function automatic data_t read_value(input region_sel_t s, input logic rd,
		input logic [23:0] baddr, input slave_rdata_t d);
		data_t v;
		v = '0;
		if (rd) begin
			if (s.chip)   v |= d.chip;
			if (s.kick)   v |= d.kick;
			if (s.custom) v |= d.custom;
			if (s.cia_a)  v |= {8'h00, d.cia_a};  // low lane
			if (s.cia_b)  v |= {d.cia_b, 8'h00};  // high lane
			if (s.rtc)    v |= {12'h000, d.rtc[int'(baddr[5:2]) * 4 +: 4]};
		end
		return v;
	endfunction

	function automatic logic [2:0] ipl_expected(input logic [IRQ_LEVELS-1:0] bits,
		input logic nmi_bit);
		logic [2:0] lvl;
		lvl = 3'd0;
		for (int i = IRQ_LEVELS; i >= 1; i--) begin
			if (lvl == 3'd0 && bits[i-1])
				lvl = 3'(i); // first hit from the top
		end
		if (nmi_bit)
			lvl = 3'd7;
		return ~lvl;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	// ------------------------------------------------------------
	// cpu model, one request then wait for ack
	task automatic bus_access(input logic [23:0] baddr, input logic rd,
		input region_sel_t sel_exp);
		cpu_req_t     r;
		slave_rdata_t d;
		int           n;
		@(posedge clk);
		d       = {$random(seed), $random(seed), $random(seed), $random(seed)};
		r       = '0;
		r.valid = 1'b1;
		r.addr  = baddr[23:1];
		r.rd    = rd;
		r.lwr   = ~rd & baddr[0];  // odd byte on the low lane
		r.hwr   = ~rd & ~baddr[0];
		r.wdata = d.chip;
		req       <= r;
		rdata     <= d;
		exp_sel   <= sel_exp;
		exp_rdata <= read_value(sel_exp, rd, baddr, d);
		n = 0;
		@(posedge clk);
		while (!ack) begin
			n++;
			if (n > ACK_TIMEOUT)
				report_error($sformatf("no ack for the request at address %h", baddr));
			@(posedge clk);
		end
		req.valid <= 1'b0; // dropped in the cycle after ack
	endtask

	task automatic wait_cpu_release();
		int n;
		n = 0;
		while (!cpu_reset_n) begin
			@(posedge clk);
			n++;
			if (n > RELEASE_TIMEOUT)
				report_error("cpu reset was never released");
		end
	endtask

	// ------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		sof = 1'b0;
		forever begin
			repeat (SOF_PERIOD - 1) @(posedge clk);
			sof <= 1'b1;
			@(posedge clk);
			sof <= 1'b0;
		end
	end

	always @(posedge clk) begin
		exp_ipl  <= ipl_expected(int_req, nmi);
		sel_prev <= sel;
		ext_pipe <= {ext_pipe[0], rst_ext};
		// hold count restarts once the synced cause is seen
		if (!rst_n || ext_pipe[1])
			sof_cnt <= 0;
		else if (sof)
			sof_cnt <= sof_cnt + 1;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
	end

	// ------------------------------------------------------------
	initial begin
		rst_n     = 1'b0;
		rst_ext   = 1'b0;
		req       = '0;
		rdata     = '0;
		int_req   = '0;
		nmi       = 1'b0;
		exp_sel   = SEL_NONE;
		exp_rdata = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		wait_cpu_release();
		bus_access(24'h000100, 1'b1, SEL_KICK);  // overlay still on
		bus_access(24'h100000, 1'b1, SEL_CHIP);
		bus_access(24'hF80010, 1'b1, SEL_KICK);
		bus_access(24'hFFFFFE, 1'b1, SEL_KICK);
		bus_access(24'hDFF006, 1'b1, SEL_CUSTOM);
		bus_access(24'hBFE001, 1'b1, SEL_CIA_A);
		bus_access(24'hBFD100, 1'b1, SEL_CIA_B);
		bus_access(24'hBFC000, 1'b1, SEL_CIA_AB); // a12 and a13 both low
		bus_access(24'h400000, 1'b1, SEL_NONE);   // hole in the map
		for (int i = 0; i < 16; i++)
			bus_access(24'hDC0000 + 24'(i * 4), 1'b1, SEL_RTC);
		bus_access(24'hBFE001, 1'b0, SEL_CIA_A);  // first cia-a write
		bus_access(24'h000100, 1'b1, SEL_CHIP);

		// interrupt priority, corners first
		@(posedge clk);
		int_req <= '1;
		nmi     <= 1'b1;
		@(posedge clk);
		nmi <= 1'b0;
		repeat (IRQ_CYCLES) begin
			@(posedge clk);
			int_req <= IRQ_LEVELS'($random(seed));
			nmi     <= ($random(seed) & 32'h7) == 32'h0;
		end
		@(posedge clk);
		int_req <= '0;
		nmi     <= 1'b0;

		// external reset brings the overlay back
		@(posedge clk);
		rst_ext <= 1'b1;
		repeat (4) @(posedge clk);
		rst_ext <= 1'b0;
		wait_cpu_release();
		bus_access(24'h000100, 1'b1, SEL_KICK);
		repeat (2) @(posedge clk);
		$display("All checks passed");
		$finish;
	end

	// ------------------------------------------------------------
	// checks
	a_reset_state: assert property (@(posedge clk) (rst_n && !$past(rst_n)) |->
		(!ack && sel == '0 && ipl_n == 3'b111 && !cpu_reset_n))
		else report_error("outputs not in their reset state when rst_n is released");
	a_hold_frames: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(sys_reset) |-> ($past(sof) && sof_cnt == RESET_HOLD_FRAMES))
		else report_error("sys_reset did not end on the required sof pulse");
	a_cpu_release: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cpu_reset_n) == ($past(sys_reset, 3) && !$past(sys_reset, 2) &&
		!$past(sys_reset, 1)))
		else report_error("cpu_reset_n not released 2 cycles after sys_reset");
	a_ext_reset: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_ext, 3) |-> (sys_reset && !cpu_reset_n))
		else report_error("rst_ext did not put the system back in reset");
	a_ack_timing: assert property (@(posedge clk) disable iff (!cpu_reset_n)
		ack == ($past(req.valid, 2) && !$past(req.valid, 3)))
		else report_error("ack not exactly 2 cycles after valid rose");
	a_sel: assert property (@(posedge clk) disable iff (!cpu_reset_n)
		ack |-> sel_prev == exp_sel)
		else report_error($sformatf("** Error: sel %h, expected %h",
			$sampled(sel_prev), $sampled(exp_sel)));
	a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> cpu_rdata == exp_rdata)
		else report_error($sformatf("** Error: cpu_rdata %h, expected %h",
			$sampled(cpu_rdata), $sampled(exp_rdata)));
	a_ipl: assert property (@(posedge clk) disable iff (!rst_n)
		ipl_n == exp_ipl)
		else report_error($sformatf("** Error: ipl_n %h, expected %h",
			$sampled(ipl_n), $sampled(exp_ipl)));

endmodule

`default_nettype wire

// ==== chipbus.f ====
rtl/chipbus_pkg.sv
rtl/addr_decoder.sv
rtl/read_return.sv
rtl/irq_encoder.sv
rtl/reset_ctrl.sv
rtl/chipbus_top.sv
bench/chipbus_tb.sv

// ==== rtl/addr_decoder.sv ====
/*
  cpu address decoder with boot rom overlay
  one strobe per request, taken on the rising edge of valid
  the cpu must hold the request stable until ack
  sel_q is high for exactly one cycle per request
*/
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
	input  logic                     clk,
	input  logic                     sys_reset,
	input  chipbus_pkg::cpu_req_t    req,
	output chipbus_pkg::region_sel_t sel_q,
	output logic                     strobe,
	output logic                     rd_q,
	output chipbus_pkg::addr_t       addr_q
);
	import chipbus_pkg::*;

	logic        valid_q;  // valid seen last cycle
	logic        start;    // first cycle of a request
	logic        ovl;      // rom overlay on low chip space
	logic [23:0] baddr;    // byte address
	region_sel_t sel_d;

	assign start = req.valid & ~valid_q;
	assign baddr = {req.addr, 1'b0};

	// ------------------------------------------------------------
	// address map
	always_comb begin
		sel_d = '0;
		if (baddr <= CHIP_TOP) begin
			// overlay only redirects reads, writes still land in chip ram
			if (ovl && req.rd && baddr <= OVL_TOP)
				sel_d.kick = 1'b1;
			else
				sel_d.chip = 1'b1;
		end
		if (baddr[23:16] == CIA_PAGE) begin
			sel_d.cia_a = ~baddr[12]; // $bfexxx
			sel_d.cia_b = ~baddr[13]; // $bfdxxx, both on a12=a13=0
		end
		if (baddr[23:12] == CUSTOM_BASE[23:12])
			sel_d.custom = 1'b1;
		if (baddr[23:16] == RTC_PAGE)
			sel_d.rtc = 1'b1;
		if (baddr >= KICK_BASE)
			sel_d.kick = 1'b1;
	end

	// ------------------------------------------------------------
	// control regs
	always_ff @(posedge clk) begin
		if (sys_reset) begin
			valid_q <= 1'b0;
			strobe  <= 1'b0;
			sel_q   <= '0;
			ovl     <= 1'b1; // boot from rom
		end else begin
			valid_q <= req.valid;
			strobe  <= start;
			sel_q   <= start ? sel_d : '0;
			if (strobe && sel_q.cia_a && !rd_q)
				ovl <= 1'b0; // first cia-a write drops overlay
		end
	end

	// request payload, held for read_return
	always_ff @(posedge clk) begin
		if (start) begin
			rd_q   <= req.rd;
			addr_q <= req.addr;
		end
	end

	// rom and chip ram never share a cycle, overlay or not
	a_kick_chip_excl: assert property (@(posedge clk) disable iff (sys_reset)
		!(sel_q.kick && sel_q.chip));

endmodule

`default_nettype wire

// ==== rtl/chipbus_pkg.sv ====
/*
  shared types and memory map for the cpu bus fabric
  chip ram fixed at 2 MB, no slow or fast ram
  addresses are word addresses (bits 23..1), constants are byte addresses
  reset hold counts sof pulses, so sof must toggle during reset
*/
`default_nettype none

package chipbus_pkg;

	// ------------------------------------------------------------
	// basic bus types
	typedef logic [23:1] addr_t;   // cpu word address
	typedef logic [15:0] data_t;   // bus word

	typedef struct packed {
		logic  valid;  // request pending
		addr_t addr;
		logic  rd;     // read cycle
		logic  hwr;    // upper byte write
		logic  lwr;    // lower byte write
		data_t wdata;
	} cpu_req_t;      // 43 bits

	typedef struct packed {
		logic chip;
		logic kick;
		logic cia_a;
		logic cia_b;
		logic custom;
		logic rtc;
	} region_sel_t;   // all zero -> unmapped

	typedef struct packed {
		data_t       chip;
		data_t       kick;
		data_t       custom;
		logic [7:0]  cia_a;   // low byte lane
		logic [7:0]  cia_b;   // high byte lane
		logic [63:0] rtc;     // 16 nibbles
	} slave_rdata_t;  // 128 bits

	// ------------------------------------------------------------
	// memory map
	localparam logic [23:0] CHIP_TOP    = 24'h1F_FFFF;
	localparam logic [23:0] OVL_TOP     = 24'h07_FFFF; // rom mirror while booting
	localparam logic [7:0]  CIA_PAGE    = 8'hBF;
	localparam logic [7:0]  RTC_PAGE    = 8'hDC;
	localparam logic [23:0] CUSTOM_BASE = 24'hDF_F000; // 4 KB of registers
	localparam logic [23:0] KICK_BASE   = 24'hF8_0000; // 512 KB up to the top

	// interrupts and reset
	localparam int IRQ_LEVELS        = 6;
	localparam int RESET_HOLD_FRAMES = 2;
	localparam int CPU_RESET_DELAY   = 2; // must be 2 or more
	localparam int FRAME_CNT_W       = $clog2(RESET_HOLD_FRAMES + 1);

endpackage

`default_nettype wire

// ==== rtl/chipbus_top.sv ====
/*
  cpu side bus fabric top level
  one request in flight, ack two cycles after valid rises
  sel goes out to the slaves, which answer in the same cycle
*/
`timescale 1ns/1ps
`default_nettype none

module chipbus_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               rst_ext,
	input  logic                               sof,
	input  chipbus_pkg::cpu_req_t              req,
	input  chipbus_pkg::slave_rdata_t          rdata,
	input  logic [chipbus_pkg::IRQ_LEVELS-1:0] int_req,
	input  logic                               nmi,
	output chipbus_pkg::region_sel_t           sel,
	output chipbus_pkg::data_t                 cpu_rdata,
	output logic                               ack,
	output logic [2:0]                         ipl_n,
	output logic                               sys_reset,
	output logic                               cpu_reset_n
);
	import chipbus_pkg::*;

	// decoder to read path
	logic  strobe;
	logic  rd_q;
	addr_t addr_q;

	// ------------------------------------------------------------
	addr_decoder u_dec (
		.clk       (clk),
		.sys_reset (sys_reset),
		.req       (req),
		.sel_q     (sel),
		.strobe    (strobe),
		.rd_q      (rd_q),
		.addr_q    (addr_q)
	);

	read_return u_ret (
		.clk       (clk),
		.rst_n     (rst_n),
		.sel_q     (sel),
		.strobe    (strobe),
		.rd_q      (rd_q),
		.addr_q    (addr_q),
		.rdata     (rdata),
		.cpu_rdata (cpu_rdata),
		.ack       (ack)
	);

	irq_encoder u_irq (
		.clk     (clk),
		.rst_n   (rst_n),
		.int_req (int_req),
		.nmi     (nmi),
		.ipl_n   (ipl_n)
	);

	// reset sequencing, also restores the overlay
	reset_ctrl u_rst (
		.clk         (clk),
		.rst_n       (rst_n),
		.rst_ext     (rst_ext),
		.sof         (sof),
		.sys_reset   (sys_reset),
		.cpu_reset_n (cpu_reset_n)
	);

endmodule

`default_nettype wire

// ==== rtl/irq_encoder.sv ====
/*
  interrupt priority encoder for the 68k ipl lines
  int_req[0] is level 1, int_req[IRQ_LEVELS-1] the highest maskable
  nmi forces level 7, output registered and active low
*/
`timescale 1ns/1ps
`default_nettype none

module irq_encoder (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [chipbus_pkg::IRQ_LEVELS-1:0] int_req,
	input  logic                              nmi,
	output logic [2:0]                        ipl_n
);
	import chipbus_pkg::*;

	logic [2:0] lvl; // highest active level, 0 = none

	always_comb begin
		lvl = 3'd0;
		for (int i = 0; i < IRQ_LEVELS; i++) begin
			if (int_req[i])
				lvl = 3'(i + 1); // later wins, so highest sticks
		end
		if (nmi)
			lvl = 3'd7;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			ipl_n <= 3'b111; // no request
		else
			ipl_n <= ~lvl;
	end

	// level 7 overrides any pattern one cycle on
	a_nmi_level7: assert property (@(posedge clk) disable iff (!rst_n)
		nmi |=> (ipl_n == 3'b000));

endmodule

`default_nettype wire

// ==== rtl/read_return.sv ====
/*
  read data return and ack for the cpu
  slaves present data in the cycle their select is high
  result and ack are registered, one cycle after the strobe
*/
`timescale 1ns/1ps
`default_nettype none

module read_return (
	input  logic                      clk,
	input  logic                      rst_n,
	input  chipbus_pkg::region_sel_t  sel_q,
	input  logic                      strobe,
	input  logic                      rd_q,
	input  chipbus_pkg::addr_t        addr_q,
	input  chipbus_pkg::slave_rdata_t rdata,
	output chipbus_pkg::data_t        cpu_rdata,
	output logic                      ack
);
	import chipbus_pkg::*;

	logic [3:0] nibble;    // rtc digit
	data_t      chip_w;
	data_t      kick_w;
	data_t      custom_w;
	data_t      cia_w;
	data_t      rtc_w;
	data_t      merged;

	// ------------------------------------------------------------
	// gate each source by its select
	assign nibble   = rdata.rtc[{addr_q[5:2], 2'b00} +: 4]; // a5..a2 picks digit
	assign chip_w   = sel_q.chip   ? rdata.chip   : '0;
	assign kick_w   = sel_q.kick   ? rdata.kick   : '0;
	assign custom_w = sel_q.custom ? rdata.custom : '0;
	assign rtc_w    = sel_q.rtc    ? {12'h000, nibble} : '0;

	// cia-b on the upper lane, cia-a on the lower
	assign cia_w = {sel_q.cia_b ? rdata.cia_b : 8'h00,
	                sel_q.cia_a ? rdata.cia_a : 8'h00};

	// writes and unmapped space read back zero
	assign merged = rd_q ? (chip_w | kick_w | custom_w | cia_w | rtc_w) : '0;

	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= strobe;
	end

	always_ff @(posedge clk) begin
		cpu_rdata <= merged; // only meaningful with ack
	end

	// decoder strobes once per request, so ack is a single pulse
	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		ack |=> !ack);

endmodule

`default_nettype wire

// ==== rtl/reset_ctrl.sv ====
/*
  system and cpu reset sequencing
  rst_ext is asynchronous and goes through two flops
  sys_reset outlasts its cause by RESET_HOLD_FRAMES sof pulses
  cpu_reset_n follows the fall of sys_reset by CPU_RESET_DELAY cycles
*/
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic rst_ext,
	input  logic sof,
	output logic sys_reset,
	output logic cpu_reset_n
);
	import chipbus_pkg::*;

	logic [1:0]                 ext_sync;  // rst_ext synchronizer
	logic [FRAME_CNT_W-1:0]     frame_cnt; // sof pulses since cause ended
	logic [CPU_RESET_DELAY-1:0] cpu_dly;   // ones shift in after release

	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ext_sync  <= '0;
			sys_reset <= 1'b1;
			frame_cnt <= '0;
			cpu_dly   <= '0;
		end else begin
			ext_sync <= {ext_sync[0], rst_ext};

			if (ext_sync[1]) begin
				sys_reset <= 1'b1; // restart the hold
				frame_cnt <= '0;
			end else if (sys_reset && sof) begin
				if (frame_cnt == FRAME_CNT_W'(RESET_HOLD_FRAMES - 1))
					sys_reset <= 1'b0;
				frame_cnt <= frame_cnt + 1'b1;
			end

			// clear on the cause too, so cpu reset drops with sys_reset
			if (sys_reset || ext_sync[1])
				cpu_dly <= '0;
			else
				cpu_dly <= {cpu_dly[CPU_RESET_DELAY-2:0], 1'b1};
		end
	end

	assign cpu_reset_n = cpu_dly[CPU_RESET_DELAY-1];

	a_cpu_in_reset: assert property (@(posedge clk)
		sys_reset |-> !cpu_reset_n);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module chipbus_tb -f chipbus.f -o chipbus_sim &&
./obj_dir/chipbus_sim | grep "All checks passed" ||
{ echo "simulation failed"; exit 1; }
